// File: hw/input_arbiter.sv
// Packet-level round-robin arbiter; merges the three input streams and stamps src_port
module input_arbiter
  import nic_pkg::*;
(
  input  logic                 axis_aclk,
  input  logic                 rst_n,
  input  axis_beat_t           s_axis [num_ports],
  input  logic [num_ports-1:0] s_valid,
  output logic [num_ports-1:0] s_ready,
  output axis_beat_t           arb_beat,
  output logic                 arb_valid,
  input  logic                 arb_ready,
  output logic [num_ports-1:0] rx_pkt
);

  logic [1:0] ptr;     // First port searched for the next packet
  logic [1:0] cur;     // Port that owns the grant mid-packet
  logic       in_pkt;
  logic [1:0] pick;
  logic [1:0] idx;
  logic       found;
  logic [1:0] sel;
  logic       have_grant;
  logic       xfer;

  // Search from the pointer for the first port with data
  always_comb begin
    pick  = ptr;
    found = 1'b0;
    idx   = ptr;
    for (int k = 0; k < num_ports; k++) begin
      idx = 2'((int'(ptr) + k) % num_ports);
      if (!found && s_valid[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  assign sel        = in_pkt ? cur : pick;
  assign have_grant = in_pkt | found;
  assign arb_valid  = have_grant & s_valid[sel];
  assign xfer       = arb_valid & arb_ready;

  always_comb begin
    arb_beat                = s_axis[sel];
    arb_beat.tuser.src_port = port_mask_t'(1 << sel);
  end

  always_comb begin
    s_ready      = '0;
    rx_pkt       = '0;
    s_ready[sel] = have_grant & arb_ready;
    rx_pkt[sel]  = xfer & arb_beat.tlast;
  end

  // Grant is held until the last beat, then the pointer moves past the winner
  always_ff @(posedge axis_aclk) begin
    if (!rst_n) begin
      ptr    <= '0;
      cur    <= '0;
      in_pkt <= 1'b0;
    end else if (xfer) begin
      if (arb_beat.tlast) begin
        in_pkt <= 1'b0;
        ptr    <= (sel == 2'(num_ports - 1)) ? 2'd0 : sel + 2'd1;
      end else begin
        in_pkt <= 1'b1;
        cur    <= sel;
      end
    end
  end

endmodule

// File: hw/nf_datapath.sv
// Top of the NIC pipeline; wires arbiter, lookup, output queues and register block
module nf_datapath
  import nic_pkg::*;
(
  input  logic                 axis_aclk,
  input  logic                 rst_n,
  input  axis_beat_t           s_axis [num_ports],
  input  logic [num_ports-1:0] s_valid,
  output logic [num_ports-1:0] s_ready,
  output axis_beat_t           m_axis [num_ports],
  output logic [num_ports-1:0] m_valid,
  input  logic [num_ports-1:0] m_ready,
  input  axil_req_t            axil_req,
  output axil_rsp_t            axil_rsp
);

  // ------------------------------------------------------------
  // Pipeline links and event pulses
  // ------------------------------------------------------------
  axis_beat_t           arb_beat;
  logic                 arb_valid;
  logic                 arb_ready;
  axis_beat_t           lkp_beat;
  logic                 lkp_valid;
  logic                 lkp_drop;
  logic                 lkp_ready;
  logic [num_ports-1:0] rx_pkt;
  logic [num_ports-1:0] tx_pkt;
  logic                 drop_pkt;

  input_arbiter input_arbiter_i (
    .axis_aclk (axis_aclk),
    .rst_n     (rst_n),
    .s_axis    (s_axis),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .arb_beat  (arb_beat),
    .arb_valid (arb_valid),
    .arb_ready (arb_ready),
    .rx_pkt    (rx_pkt)
  );

  output_port_lookup output_port_lookup_i (
    .axis_aclk (axis_aclk),
    .rst_n     (rst_n),
    .arb_beat  (arb_beat),
    .arb_valid (arb_valid),
    .arb_ready (arb_ready),
    .lkp_beat  (lkp_beat),
    .lkp_valid (lkp_valid),
    .lkp_drop  (lkp_drop),
    .lkp_ready (lkp_ready)
  );

  output_queues output_queues_i (
    .axis_aclk (axis_aclk),
    .rst_n     (rst_n),
    .lkp_beat  (lkp_beat),
    .lkp_valid (lkp_valid),
    .lkp_drop  (lkp_drop),
    .lkp_ready (lkp_ready),
    .m_axis    (m_axis),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .tx_pkt    (tx_pkt),
    .drop_pkt  (drop_pkt)
  );

  nic_regs nic_regs_i (
    .axis_aclk (axis_aclk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .rx_pkt    (rx_pkt),
    .tx_pkt    (tx_pkt),
    .drop_pkt  (drop_pkt)
  );

endmodule

// File: hw/nic_pkg.sv
// Shared widths, port numbering, register map and bus structs; import with nic_pkg::*
package nic_pkg;

  // ------------------------------------------------------------
  // Stream geometry and port numbering
  // ------------------------------------------------------------
  localparam int num_ports  = 3;
  localparam int port_mac0  = 0;
  localparam int port_mac1  = 1;
  localparam int port_dma   = 2;
  localparam int data_width = 64;
  localparam int keep_width = 8;
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef logic [7:0] port_mask_t;

  localparam port_mask_t mask_mac0 = port_mask_t'(1 << port_mac0);
  localparam port_mask_t mask_mac1 = port_mask_t'(1 << port_mac1);
  localparam port_mask_t mask_dma  = port_mask_t'(1 << port_dma);

  // Metadata word carried in tuser
  typedef struct packed {
    logic [15:0] pkt_len;
    port_mask_t  src_port;
    port_mask_t  dst_port;
  } meta_t;

  typedef struct packed {
    logic [data_width-1:0] tdata;
    logic [keep_width-1:0] tkeep;
    meta_t                 tuser;
    logic                  tlast;
  } axis_beat_t;

  // ------------------------------------------------------------
  // AXI4-Lite register bus
  // ------------------------------------------------------------
  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // Register map
  localparam logic [31:0] reg_id      = 32'h00;
  localparam logic [31:0] reg_ctrl    = 32'h04;
  localparam logic [31:0] reg_rx_base = 32'h10;
  localparam logic [31:0] reg_tx_base = 32'h20;
  localparam logic [31:0] reg_drop    = 32'h30;
  localparam logic [31:0] id_value    = 32'h4E46_4E43;

  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

endpackage

// File: hw/nic_regs.sv
// AXI4-Lite register slave with identity, control and packet counters
module nic_regs
  import nic_pkg::*;
(
  input  logic                 axis_aclk,
  input  logic                 rst_n,
  input  axil_req_t            axil_req,
  output axil_rsp_t            axil_rsp,
  input  logic [num_ports-1:0] rx_pkt,
  input  logic [num_ports-1:0] tx_pkt,
  input  logic                 drop_pkt
);

  logic [31:0] rx_cnt [num_ports];
  logic [31:0] tx_cnt [num_ports];
  logic [31:0] drop_cnt;
  logic        aw_hs;
  logic        ar_hs;
  logic        clr;
  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;
  logic [32:0] rd_lookup;
  logic [32:0] wr_lookup;

  // Returns {hit, read data}; unmapped addresses read as zero
  function automatic logic [32:0] reg_lookup(input logic [31:0] addr);
    logic [32:0] res;
    res = '0;
    if (addr == reg_id) begin
      res = {1'b1, id_value};
    end
    if (addr == reg_ctrl) begin
      res = {1'b1, 32'h0};
    end
    if (addr == reg_drop) begin
      res = {1'b1, drop_cnt};
    end
    for (int i = 0; i < num_ports; i++) begin
      if (addr == reg_rx_base + 32'(4 * i)) begin
        res = {1'b1, rx_cnt[i]};
      end
      if (addr == reg_tx_base + 32'(4 * i)) begin
        res = {1'b1, tx_cnt[i]};
      end
    end
    return res;
  endfunction

  always_comb begin
    rd_lookup = reg_lookup(axil_req.araddr);
    wr_lookup = reg_lookup(axil_req.awaddr);
  end

  // ------------------------------------------------------------
  // Channel handshakes
  // ------------------------------------------------------------
  assign aw_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign ar_hs = axil_req.arvalid && !rvalid_q;
  assign clr   = aw_hs && (axil_req.awaddr == reg_ctrl) && axil_req.wstrb[0]
                 && axil_req.wdata[0];

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = aw_hs;
    axil_rsp.wready  = aw_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = ar_hs;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rresp   = rresp_q;
    axil_rsp.rdata   = rdata_q;
  end

  always_ff @(posedge axis_aclk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (aw_hs) begin
      bresp_q <= wr_lookup[32] ? resp_okay : resp_slverr;
    end
    if (ar_hs) begin
      rresp_q <= rd_lookup[32] ? resp_okay : resp_slverr;
      rdata_q <= rd_lookup[31:0];
    end
  end

  // ------------------------------------------------------------
  // Event counters that wrap at 2^32
  // ------------------------------------------------------------
  always_ff @(posedge axis_aclk) begin
    if (!rst_n || clr) begin
      drop_cnt <= '0;
      for (int i = 0; i < num_ports; i++) begin
        rx_cnt[i] <= '0;
        tx_cnt[i] <= '0;
      end
    end else begin
      drop_cnt <= drop_cnt + 32'(drop_pkt);
      for (int i = 0; i < num_ports; i++) begin
        rx_cnt[i] <= rx_cnt[i] + 32'(rx_pkt[i]);
        tx_cnt[i] <= tx_cnt[i] + 32'(tx_pkt[i]);
      end
    end
  end

endmodule

// File: hw/output_port_lookup.sv
// One-stage registered lookup; picks the destination port or marks the packet for drop
module output_port_lookup
  import nic_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       rst_n,
  input  axis_beat_t arb_beat,
  input  logic       arb_valid,
  output logic       arb_ready,
  output axis_beat_t lkp_beat,
  output logic       lkp_valid,
  output logic       lkp_drop,
  input  logic       lkp_ready
);

  logic       sop;       // Next input beat starts a packet
  port_mask_t hold_dst;
  logic       hold_drop;
  port_mask_t new_dst;
  logic       new_drop;
  port_mask_t dst_sel;
  logic       drop_sel;
  logic       xfer_in;

  // MAC traffic goes to DMA; DMA traffic needs exactly one MAC bit
  always_comb begin
    if (arb_beat.tuser.src_port == mask_dma) begin
      new_dst  = arb_beat.tuser.dst_port;
      new_drop = !(new_dst == mask_mac0 || new_dst == mask_mac1);
    end else begin
      new_dst  = mask_dma;
      new_drop = 1'b0;
    end
  end

  // Decision made on the first beat covers the whole packet
  assign dst_sel   = sop ? new_dst : hold_dst;
  assign drop_sel  = sop ? new_drop : hold_drop;
  assign arb_ready = !lkp_valid || lkp_ready;
  assign xfer_in   = arb_valid && arb_ready;

  always_ff @(posedge axis_aclk) begin
    if (!rst_n) begin
      lkp_valid <= 1'b0;
      sop       <= 1'b1;
    end else begin
      if (xfer_in) begin
        lkp_valid <= 1'b1;
        sop       <= arb_beat.tlast;
      end else if (lkp_ready) begin
        lkp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (xfer_in) begin
      lkp_beat                <= arb_beat;
      lkp_beat.tuser.dst_port <= dst_sel;
      lkp_drop                <= drop_sel;
      hold_dst                <= dst_sel;
      hold_drop               <= drop_sel;
    end
  end

endmodule

// File: hw/output_queues.sv
// Output queue stage; steers each beat to its destination FIFO and discards dropped packets
module output_queues
  import nic_pkg::*;
(
  input  logic                 axis_aclk,
  input  logic                 rst_n,
  input  axis_beat_t           lkp_beat,
  input  logic                 lkp_valid,
  input  logic                 lkp_drop,
  output logic                 lkp_ready,
  output axis_beat_t           m_axis [num_ports],
  output logic [num_ports-1:0] m_valid,
  input  logic [num_ports-1:0] m_ready,
  output logic [num_ports-1:0] tx_pkt,
  output logic                 drop_pkt
);

  logic [num_ports-1:0] tgt;
  logic [num_ports-1:0] full;
  logic [num_ports-1:0] empty;
  logic [num_ports-1:0] wr_en;
  logic [num_ports-1:0] rd_en;

  // dst_port is one-hot after lookup, so it selects the queue directly
  assign tgt       = lkp_beat.tuser.dst_port[num_ports-1:0];
  assign lkp_ready = lkp_drop | ~|(tgt & full);
  assign wr_en     = {num_ports{lkp_valid & ~lkp_drop}} & tgt & ~full;
  assign drop_pkt  = lkp_valid & lkp_drop & lkp_beat.tlast;
  assign m_valid   = ~empty;
  assign rd_en     = m_valid & m_ready;

  for (genvar i = 0; i < num_ports; i++) begin : g_queue
    pkt_fifo pkt_fifo_i (
      .axis_aclk (axis_aclk),
      .rst_n     (rst_n),
      .wr_beat   (lkp_beat),
      .wr_en     (wr_en[i]),
      .rd_en     (rd_en[i]),
      .rd_beat   (m_axis[i]),
      .full      (full[i]),
      .empty     (empty[i])
    );

    assign tx_pkt[i] = rd_en[i] & m_axis[i].tlast;
  end

endmodule

// File: hw/pkt_fifo.sv
// Synchronous first-word-fall-through beat FIFO backing one output queue
module pkt_fifo
  import nic_pkg::*;
(
  input  logic       axis_aclk,
  input  logic       rst_n,
  input  axis_beat_t wr_beat,
  input  logic       wr_en,
  input  logic       rd_en,
  output axis_beat_t rd_beat,
  output logic       full,
  output logic       empty
);

  axis_beat_t            mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign full    = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign empty   = (count == '0);
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign rd_beat = mem[rd_ptr];

  always_ff @(posedge axis_aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy holds when a write and a read meet
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the simulation result
set -e

cd "$(dirname "$0")"

verilator --binary --timing -sv -f sim.f \
  --top-module tb_nf_datapath \
  -Mdir obj_dir -o tb_nf_datapath

./obj_dir/tb_nf_datapath

// File: sim.f
hw/nic_pkg.sv
hw/input_arbiter.sv
hw/output_port_lookup.sv
hw/pkt_fifo.sv
hw/output_queues.sv
hw/nic_regs.sv
hw/nf_datapath.sv
test/clk_gen.sv
test/tb_nf_datapath.sv

// File: test/clk_gen.sv
// Testbench clock source; free-running clock with an 8-unit period for the DUT
module clk_gen (
  output logic clk
);

  localparam int half_period = 4;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period;
      clk = ~clk;
    end
  end

endmodule

// File: test/tb_nf_datapath.sv
// Directed testbench for nf_datapath; drives the three stream ports and the AXI4-Lite bus
module tb_nf_datapath
  import nic_pkg::*;
();

  localparam logic [31:0] seed  = 32'h437c_d9fc;
  // Beats sent by tests 1 to 5 together
  localparam int total_beats     = 46;
  localparam int watchdog_cycles = 20 * total_beats + 2000;

  logic                 clk;
  logic                 rst_n;
  axis_beat_t           s_axis [num_ports];
  logic [num_ports-1:0] s_valid;
  logic [num_ports-1:0] s_ready;
  axis_beat_t           m_axis [num_ports];
  logic [num_ports-1:0] m_valid;
  logic [num_ports-1:0] m_ready = '1;
  axil_req_t            axil_req;
  axil_rsp_t            axil_rsp;

  // Beats waiting to be driven on each input port
  axis_beat_t tx_q [num_ports][$];
  // Expected beats indexed by output port * num_ports + source port
  axis_beat_t exp_q [num_ports * num_ports][$];
  int         rx_exp [num_ports];
  int         tx_exp [num_ports];
  int         drop_exp;
  int         cyc = 0;
  int         stall_end = 0;

  clk_gen clk_gen_i (
    .clk (clk)
  );

  nf_datapath nf_datapath_i (
    .axis_aclk (clk),
    .rst_n     (rst_n),
    .s_axis    (s_axis),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .m_axis    (m_axis),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
  );

  // ------------------------------------------------------------
  // Reporting and scoreboard helpers
  // ------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic int mask_to_port(input port_mask_t m);
    int idx;
    idx = -1;
    for (int p = 0; p < num_ports; p++) begin
      if (m == port_mask_t'(1 << p)) begin
        idx = p;
      end
    end
    return idx;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < num_ports * num_ports; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  // ------------------------------------------------------------
  // Stream stimulus
  // ------------------------------------------------------------
  // Queues one packet and records where the forwarding rules send it
  task automatic build_packet(input int port, input port_mask_t dst, input int nbeats);
    axis_beat_t beat;
    axis_beat_t exp_beat;
    int         out;
    out = -1;
    if (port != port_dma) begin
      out = port_dma;
    end else if (dst == mask_mac0) begin
      out = port_mac0;
    end else if (dst == mask_mac1) begin
      out = port_mac1;
    end
    rx_exp[port]++;
    if (out < 0) begin
      drop_exp++;
    end else begin
      tx_exp[out]++;
    end
    for (int b = 0; b < nbeats; b++) begin
      beat.tdata          = {$urandom, $urandom};
      beat.tlast          = (b == nbeats - 1);
      beat.tkeep          = beat.tlast ? 8'h0F : 8'hFF;
      beat.tuser.pkt_len  = 16'(nbeats * 8 - 4);
      // Junk source field that the arbiter must overwrite
      beat.tuser.src_port = port_mask_t'($urandom);
      beat.tuser.dst_port = dst;
      tx_q[port].push_back(beat);
      exp_beat                = beat;
      exp_beat.tuser.src_port = port_mask_t'(1 << port);
      if (out == port_dma) begin
        exp_beat.tuser.dst_port = mask_dma;
      end
      if (out >= 0) begin
        exp_q[out * num_ports + port].push_back(exp_beat);
      end
    end
  endtask

  // Drives every input port from its queue until all queues are empty
  task automatic run_senders();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int p = 0; p < num_ports; p++) begin
        if (tx_q[p].size() > 0) begin
          s_axis[p]  = tx_q[p][0];
          s_valid[p] = 1'b1;
          busy       = 1'b1;
        end else begin
          s_valid[p] = 1'b0;
        end
      end
      if (busy) begin
        @(posedge clk);
        for (int p = 0; p < num_ports; p++) begin
          if (s_valid[p] && s_ready[p]) begin
            void'(tx_q[p].pop_front());
          end
        end
        #1;
      end
    end
  endtask

  task automatic wait_drain();
    while (pending() != 0) begin
      @(posedge clk);
    end
    // Lets a dropped tail leave the one-stage lookup
    repeat (4) @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------------------
  // AXI4-Lite master
  // ------------------------------------------------------------
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    do @(posedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    do @(posedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do @(posedge clk); while (!axil_rsp.arready);
    #1;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    do @(posedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_field({name, " rresp"}, 64'(resp), 64'(resp_okay));
    check_field(name, 64'(data), 64'(exp));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic mac_to_dma();
    build_packet(port_mac0, 8'h00, 4);
    run_senders();
    wait_drain();
  endtask

  task automatic dma_to_mac();
    build_packet(port_dma, mask_mac1, 3);
    build_packet(port_dma, mask_mac0, 5);
    run_senders();
    wait_drain();
  endtask

  task automatic dma_backpressure();
    stall_end = cyc + 40;
    for (int n = 0; n < 3; n++) begin
      build_packet(port_mac1, 8'h00, 6);
    end
    run_senders();
    // 18 beats exceed one queue plus the lookup stage
    assert (cyc >= stall_end) else begin
      report_fail("MAC1 sender finished while the DMA output was still stalled");
    end
    wait_drain();
  endtask

  task automatic mac_contention();
    build_packet(port_mac0, 8'h00, 5);
    build_packet(port_mac1, 8'h00, 5);
    run_senders();
    wait_drain();
  endtask

  task automatic dma_drop();
    build_packet(port_dma, 8'h00, 3);
    build_packet(port_dma, mask_dma, 3);
    run_senders();
    wait_drain();
  endtask

  task automatic register_access();
    logic [31:0] data;
    logic [1:0]  resp;
    check_reg(reg_id, id_value, "reg_id");
    for (int p = 0; p < num_ports; p++) begin
      check_reg(reg_rx_base + 32'(4 * p), 32'(rx_exp[p]), $sformatf("rx_cnt[%0d]", p));
      check_reg(reg_tx_base + 32'(4 * p), 32'(tx_exp[p]), $sformatf("tx_cnt[%0d]", p));
    end
    check_reg(reg_drop, 32'(drop_exp), "drop_cnt");
    axil_write(reg_ctrl, 32'h1, resp);
    check_field("ctrl bresp", 64'(resp), 64'(resp_okay));
    check_reg(reg_ctrl, 32'h0, "reg_ctrl");
    for (int p = 0; p < num_ports; p++) begin
      check_reg(reg_rx_base + 32'(4 * p), 32'h0, $sformatf("rx_cnt[%0d] after clear", p));
      check_reg(reg_tx_base + 32'(4 * p), 32'h0, $sformatf("tx_cnt[%0d] after clear", p));
    end
    check_reg(reg_drop, 32'h0, "drop_cnt after clear");
    axil_write(32'h40, 32'h1234_5678, resp);
    check_field("unmapped bresp", 64'(resp), 64'(resp_slverr));
    axil_read(32'h40, data, resp);
    check_field("unmapped rresp", 64'(resp), 64'(resp_slverr));
    check_field("unmapped rdata", 64'(data), 64'h0);
  endtask

  // ------------------------------------------------------------
  // Output monitor, ready driver and watchdog
  // ------------------------------------------------------------
  int cur_src [num_ports];
  bit mid_pkt [num_ports];

  always @(posedge clk) begin : monitor
    axis_beat_t got;
    axis_beat_t exp_beat;
    int         src;
    for (int i = 0; i < num_ports; i++) begin
      if (rst_n && m_valid[i] && m_ready[i]) begin
        got = m_axis[i];
        src = mask_to_port(got.tuser.src_port);
        assert (src >= 0) else begin
          report_fail($sformatf("Output port %0d sent a beat with src_port %h", i,
                                got.tuser.src_port));
        end
        assert (!mid_pkt[i] || src == cur_src[i]) else begin
          report_fail($sformatf("Output port %0d interleaved packets from ports %0d and %0d",
                                i, cur_src[i], src));
        end
        assert (exp_q[i * num_ports + src].size() > 0) else begin
          report_fail($sformatf("Unexpected beat on output port %0d from port %0d", i, src));
        end
        exp_beat = exp_q[i * num_ports + src].pop_front();
        check_field($sformatf("m_axis[%0d].tdata", i), got.tdata, exp_beat.tdata);
        check_field($sformatf("m_axis[%0d].tkeep", i), 64'(got.tkeep), 64'(exp_beat.tkeep));
        check_field($sformatf("m_axis[%0d].tuser", i), 64'(got.tuser), 64'(exp_beat.tuser));
        check_field($sformatf("m_axis[%0d].tlast", i), 64'(got.tlast), 64'(exp_beat.tlast));
        cur_src[i] = src;
        mid_pkt[i] = !got.tlast;
      end
    end
  end

  // DMA output ready stays low until the stall cycle count is reached
  always @(posedge clk) begin
    #1;
    cyc              = cyc + 1;
    m_ready          = '1;
    m_ready[port_dma] = (cyc >= stall_end);
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    report_fail($sformatf("Timeout, tests did not finish within %0d cycles", watchdog_cycles));
  end

  initial begin : main
    void'($urandom(seed));
    rst_n    = 1'b0;
    s_valid  = '0;
    axil_req = '0;
    drop_exp = 0;
    for (int p = 0; p < num_ports; p++) begin
      s_axis[p] = '0;
      rx_exp[p] = 0;
      tx_exp[p] = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    mac_to_dma();
    dma_to_mac();
    dma_backpressure();
    mac_contention();
    dma_drop();
    register_access();

    $display("Result: PASSED");
    $finish;
  end

endmodule
